//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath widths
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32
`define ALU_SEL_W   4

// Opcodes kept by this core
`define OPC_ARI_R   7'b0110011
`define OPC_ARI_I   7'b0010011
`define OPC_LUI     7'b0110111

// funct3 codes for the integer ALU group
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct7 codes, ALT picks sub and sra
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

// ALU select codes
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_SLL     4'd2
`define ALU_SLT     4'd3
`define ALU_SLTU    4'd4
`define ALU_XOR     4'd5
`define ALU_SRL     4'd6
`define ALU_SRA     4'd7
`define ALU_OR      4'd8
`define ALU_AND     4'd9
`define ALU_PASS_B  4'd10

`endif

//--- cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    // Widths with a meaning of their own
    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ALU_SEL_W-1:0]  alu_sel_t;

    ////////////////////////////////////////////////////////////////////////////
    // Decoded operation, decode to execute
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic      valid;
        // Only set for a nonzero rd
        logic      reg_write;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        alu_sel_t  alu_sel;
        logic      use_imm;
        // Operand A forced to zero
        logic      lui_op;
        word_t     imm;
    } decoded_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Writeback result, also the retirement report
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

//--- instr_decoder.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module instr_decoder (
    input  cpu_pkg::word_t      instr,
    input  logic                instr_valid,
    output cpu_pkg::decoded_op_t dec
);

    // Instruction fields
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    cpu_pkg::reg_addr_t rd;

    // Decode results before qualification
    logic              supported;
    cpu_pkg::alu_sel_t alu_sel;
    logic              use_imm;
    logic              lui_op;
    cpu_pkg::word_t    imm;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    ////////////////////////////////////////////////////////////////////////////
    // Opcode, funct3 and funct7 to ALU select
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        supported = 1'b0;
        alu_sel   = `ALU_PASS_B;
        use_imm   = 1'b0;
        lui_op    = 1'b0;
        // Sign extended I-type immediate
        imm       = {{(`XLEN-12){instr[31]}}, instr[31:20]};

        case (opcode)
            `OPC_ARI_R: begin
                supported = (funct7 == `F7_BASE);
                case (funct3)
                    `F3_ADD_SUB: begin
                        supported = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
                        alu_sel   = (funct7 == `F7_ALT) ? `ALU_SUB : `ALU_ADD;
                    end
                    `F3_SLL:  alu_sel = `ALU_SLL;
                    `F3_SLT:  alu_sel = `ALU_SLT;
                    `F3_SLTU: alu_sel = `ALU_SLTU;
                    `F3_XOR:  alu_sel = `ALU_XOR;
                    `F3_SRL_SRA: begin
                        supported = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
                        alu_sel   = (funct7 == `F7_ALT) ? `ALU_SRA : `ALU_SRL;
                    end
                    `F3_OR:   alu_sel = `ALU_OR;
                    default:  alu_sel = `ALU_AND;
                endcase
            end

            `OPC_ARI_I: begin
                supported = 1'b1;
                use_imm   = 1'b1;
                case (funct3)
                    `F3_ADD_SUB: alu_sel = `ALU_ADD;
                    `F3_SLT:     alu_sel = `ALU_SLT;
                    `F3_SLTU:    alu_sel = `ALU_SLTU;
                    `F3_XOR:     alu_sel = `ALU_XOR;
                    `F3_OR:      alu_sel = `ALU_OR;
                    `F3_AND:     alu_sel = `ALU_AND;
                    `F3_SLL: begin
                        supported = (funct7 == `F7_BASE);
                        alu_sel   = `ALU_SLL;
                        imm       = {{(`XLEN-5){1'b0}}, instr[24:20]};
                    end
                    default: begin
                        // srli and srai share funct3, shamt only
                        supported = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
                        alu_sel   = (funct7 == `F7_ALT) ? `ALU_SRA : `ALU_SRL;
                        imm       = {{(`XLEN-5){1'b0}}, instr[24:20]};
                    end
                endcase
            end

            `OPC_LUI: begin
                supported = 1'b1;
                alu_sel   = `ALU_ADD;
                use_imm   = 1'b1;
                lui_op    = 1'b1;
                imm       = {instr[31:12], 12'b0};
            end

            default: supported = 1'b0;
        endcase
    end

    // Anything unsupported leaves a bubble
    assign dec.valid     = instr_valid && supported;
    assign dec.reg_write = instr_valid && supported && (rd != '0);
    assign dec.rd        = rd;
    assign dec.rs1       = instr[19:15];
    assign dec.rs2       = instr[24:20];
    assign dec.alu_sel   = alu_sel;
    assign dec.use_imm   = use_imm;
    assign dec.lui_op    = lui_op;
    assign dec.imm       = imm;

endmodule

//--- register_file.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module register_file (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::reg_addr_t rs1_addr,
    input  cpu_pkg::reg_addr_t rs2_addr,
    output cpu_pkg::word_t     rs1_data,
    output cpu_pkg::word_t     rs2_data,
    input  cpu_pkg::wb_t       wb
);

    // x0 has no storage
    cpu_pkg::word_t regs [1:`NUM_REGS-1];

    // x0 reads zero, a same-cycle write is passed through
    function automatic cpu_pkg::word_t read_port(
        input cpu_pkg::reg_addr_t addr,
        input cpu_pkg::wb_t       wr,
        input cpu_pkg::word_t     stored
    );
        if (addr == '0) begin
            return '0;
        end else if (wr.valid && (wr.rd == addr)) begin
            return wr.data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = read_port(rs1_addr, wb, regs[rs1_addr]);
    assign rs2_data = read_port(rs2_addr, wb, regs[rs2_addr]);

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module execute_stage (
    input  logic                 clk,
    input  logic                 arst_n,
    input  cpu_pkg::decoded_op_t dec,
    input  cpu_pkg::word_t       rs1_data,
    input  cpu_pkg::word_t       rs2_data,
    output cpu_pkg::wb_t         wb
);

    // Decode to execute register
    cpu_pkg::decoded_op_t ex_op;
    cpu_pkg::word_t       ex_rs1_data;
    cpu_pkg::word_t       ex_rs2_data;

    // Execute stage values
    cpu_pkg::word_t       fwd_rs1;
    cpu_pkg::word_t       fwd_rs2;
    cpu_pkg::word_t       op_a;
    cpu_pkg::word_t       op_b;
    logic [4:0]           shamt;
    cpu_pkg::word_t       alu_result;

    // Writeback register
    logic                 wb_valid;
    cpu_pkg::reg_addr_t   wb_rd;
    cpu_pkg::word_t       wb_data;

    // Takes the writeback value when it targets the source register
    function automatic cpu_pkg::word_t forward(
        input cpu_pkg::reg_addr_t src,
        input cpu_pkg::word_t     reg_value,
        input cpu_pkg::wb_t       wr
    );
        if (wr.valid && (src != '0) && (wr.rd == src)) begin
            return wr.data;
        end
        return reg_value;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Decode to execute
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_op <= '0;
        end else begin
            ex_op <= dec;
        end
    end

    // Operand values only matter for a live op
    always_ff @(posedge clk) begin
        if (dec.valid) begin
            ex_rs1_data <= rs1_data;
            ex_rs2_data <= rs2_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding and ALU
    ////////////////////////////////////////////////////////////////////////////
    assign fwd_rs1 = forward(ex_op.rs1, ex_rs1_data, wb);
    assign fwd_rs2 = forward(ex_op.rs2, ex_rs2_data, wb);

    assign op_a  = ex_op.lui_op ? '0 : fwd_rs1;
    assign op_b  = ex_op.use_imm ? ex_op.imm : fwd_rs2;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex_op.alu_sel)
            `ALU_ADD:    alu_result = op_a + op_b;
            `ALU_SUB:    alu_result = op_a - op_b;
            `ALU_SLL:    alu_result = op_a << shamt;
            `ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            `ALU_SLTU:   alu_result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            `ALU_XOR:    alu_result = op_a ^ op_b;
            `ALU_SRL:    alu_result = op_a >> shamt;
            // Arithmetic shift keeps the sign
            `ALU_SRA:    alu_result = $signed(op_a) >>> shamt;
            `ALU_OR:     alu_result = op_a | op_b;
            `ALU_AND:    alu_result = op_a & op_b;
            `ALU_PASS_B: alu_result = op_b;
            default:     alu_result = op_b;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Execute to writeback
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_op.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_op.valid) begin
            wb_rd   <= ex_op.rd;
            wb_data <= alu_result;
        end
    end

    assign wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

endmodule

//--- rv_alu_core.sv
`timescale 1ns/1ps

module rv_alu_core (
    input  logic           clk,
    input  logic           arst_n,
    input  cpu_pkg::word_t instr,
    input  logic           instr_valid,
    output cpu_pkg::wb_t   retire
);

    cpu_pkg::decoded_op_t dec;
    cpu_pkg::word_t       rs1_data;
    cpu_pkg::word_t       rs2_data;

    // Decode, also addresses the register file
    instr_decoder dec0 (
        .instr       (instr),
        .instr_valid (instr_valid),
        .dec         (dec)
    );

    // Writeback comes back from the execute stage
    register_file rf0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (dec.rs1),
        .rs2_addr (dec.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (retire)
    );

    // Execute and writeback registers
    execute_stage ex0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .dec      (dec),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (retire)
    );

endmodule

//--- rv_alu_core_tb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module rv_alu_core_tb;

    // One table row per applied cycle
    typedef struct packed {
        logic               drive;
        cpu_pkg::word_t     instr;
        logic               retires;
        cpu_pkg::reg_addr_t rd;
        cpu_pkg::word_t     data;
    } stim_t;

    // Retirement waiting for its cycle
    typedef struct packed {
        int                 due;
        cpu_pkg::reg_addr_t rd;
        cpu_pkg::word_t     data;
    } pending_t;

    logic           clk;
    logic           arst_n;
    cpu_pkg::word_t instr;
    logic           instr_valid;
    cpu_pkg::wb_t   retire;

    stim_t          table_q [$];
    pending_t       exp_q [$];
    cpu_pkg::word_t model_regs [0:`NUM_REGS-1];
    logic [31:0]    rng_state = 32'd70;
    int             cycle;
    int             cycle_limit = 1000;

    rv_alu_core dut0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .retire      (retire)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Cycle count since reset release with a run limit
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle <= 0;
        end else if (cycle >= cycle_limit) begin
            $display("Timeout after %0d cycles, the instruction table never drained", cycle);
            $display("Test failed");
            $fatal(1);
        end else begin
            cycle <= cycle + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Encoders and reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic cpu_pkg::word_t rtype_word(input logic [2:0] f3, input logic [6:0] f7,
                                                  input logic [4:0] rd, input logic [4:0] rs1,
                                                  input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, `OPC_ARI_R};
    endfunction

    function automatic cpu_pkg::word_t itype_word(input logic [2:0] f3, input logic [4:0] rd,
                                                  input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, `OPC_ARI_I};
    endfunction

    function automatic cpu_pkg::word_t lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, `OPC_LUI};
    endfunction

    // ISA arithmetic by funct3 where alt picks sub or sra
    function automatic cpu_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                                 input cpu_pkg::word_t a, input cpu_pkg::word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? cpu_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_instr(input cpu_pkg::word_t word);
        logic [2:0]     f3;
        logic [6:0]     f7;
        logic [4:0]     rd;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t res;
        logic           ok;
        f3  = word[14:12];
        f7  = word[31:25];
        rd  = word[11:7];
        a   = model_regs[word[19:15]];
        b   = model_regs[word[24:20]];
        ok  = 1'b0;
        res = '0;
        if (word[6:0] == `OPC_ARI_R) begin
            ok = (f7 == `F7_BASE) ||
                 ((f7 == `F7_ALT) && ((f3 == `F3_ADD_SUB) || (f3 == `F3_SRL_SRA)));
            res = alu_model(f3, f7 == `F7_ALT, a, b);
        end else if (word[6:0] == `OPC_ARI_I) begin
            // Shift amount sits in imm[4:0] on the rs2 bits
            b = {{20{word[31]}}, word[31:20]};
            if (f3 == `F3_SLL) begin
                ok = (f7 == `F7_BASE);
            end else if (f3 == `F3_SRL_SRA) begin
                ok = (f7 == `F7_BASE) || (f7 == `F7_ALT);
            end else begin
                ok = 1'b1;
            end
            res = alu_model(f3, (f3 == `F3_SRL_SRA) && (f7 == `F7_ALT), a, b);
        end else if (word[6:0] == `OPC_LUI) begin
            ok  = 1'b1;
            res = {word[31:12], 12'b0};
        end
        if (ok && (rd != 5'd0)) begin
            model_regs[rd] = res;
        end
        table_q.push_back('{drive: 1'b1, instr: word, retires: ok && (rd != 5'd0),
                            rd: rd, data: res});
    endtask

    task automatic add_idle();
        table_q.push_back('{drive: 1'b0, instr: '0, retires: 1'b0, rd: '0, data: '0});
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Only x0 to x7 so that dependencies are frequent
    task automatic add_random_instr();
        logic [31:0] r;
        logic [31:0] upper;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = next_random();
        f3 = r[11:9];
        f7 = (((f3 == `F3_ADD_SUB) || (f3 == `F3_SRL_SRA)) && r[12]) ? `F7_ALT : `F7_BASE;
        case (r[26:25])
            2'd0: add_instr(rtype_word(f3, f7, {2'b0, r[2:0]}, {2'b0, r[5:3]}, {2'b0, r[8:6]}));
            2'd3: begin
                upper = next_random();
                add_instr(lui_word({2'b0, r[2:0]}, upper[19:0]));
            end
            default: begin
                if ((f3 == `F3_SLL) || (f3 == `F3_SRL_SRA)) begin
                    f7 = (f3 == `F3_SRL_SRA && r[12]) ? `F7_ALT : `F7_BASE;
                    add_instr(itype_word(f3, {2'b0, r[2:0]}, {2'b0, r[5:3]}, {f7, r[17:13]}));
                end else begin
                    add_instr(itype_word(f3, {2'b0, r[2:0]}, {2'b0, r[5:3]}, r[24:13]));
                end
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_eq(input string what, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Compares retire with the oldest pending retirement
    task automatic check_retire();
        logic due;
        due = (exp_q.size() > 0) && (exp_q[0].due == cycle);
        check_eq("retire.valid", {31'b0, retire.valid}, {31'b0, due});
        if (due) begin
            check_eq("retire.rd", {27'b0, retire.rd}, {27'b0, exp_q[0].rd});
            check_eq("retire.data", retire.data, exp_q[0].data);
            void'(exp_q.pop_front());
        end
    endtask

    initial begin
        arst_n      = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        // Directed section
        add_instr(itype_word(`F3_ADD_SUB, 5'd5, 5'd9, 12'd0));
        add_instr(lui_word(5'd1, 20'hFFFFF));
        add_instr(itype_word(`F3_ADD_SUB, 5'd1, 5'd1, 12'h123));
        add_instr(itype_word(`F3_ADD_SUB, 5'd2, 5'd0, 12'd5));
        add_instr(rtype_word(`F3_ADD_SUB, `F7_BASE, 5'd3, 5'd1, 5'd2));
        add_instr(rtype_word(`F3_ADD_SUB, `F7_ALT, 5'd4, 5'd2, 5'd1));
        add_instr(rtype_word(`F3_SLL, `F7_BASE, 5'd6, 5'd1, 5'd2));
        add_instr(rtype_word(`F3_SRL_SRA, `F7_BASE, 5'd7, 5'd1, 5'd2));
        add_instr(rtype_word(`F3_SRL_SRA, `F7_ALT, 5'd8, 5'd1, 5'd2));
        add_instr(rtype_word(`F3_SLT, `F7_BASE, 5'd9, 5'd1, 5'd2));
        add_instr(rtype_word(`F3_SLTU, `F7_BASE, 5'd10, 5'd1, 5'd2));
        add_instr(rtype_word(`F3_XOR, `F7_BASE, 5'd11, 5'd1, 5'd2));
        add_instr(rtype_word(`F3_OR, `F7_BASE, 5'd12, 5'd1, 5'd2));
        add_instr(rtype_word(`F3_AND, `F7_BASE, 5'd13, 5'd1, 5'd2));
        add_instr(itype_word(`F3_SLT, 5'd14, 5'd1, 12'd0));
        add_instr(itype_word(`F3_SLTU, 5'd15, 5'd2, 12'hFFF));
        add_instr(itype_word(`F3_XOR, 5'd16, 5'd1, 12'hFFF));
        add_instr(itype_word(`F3_OR, 5'd17, 5'd2, 12'h0F0));
        add_instr(itype_word(`F3_AND, 5'd18, 5'd1, 12'h0FF));
        add_instr(itype_word(`F3_SLL, 5'd19, 5'd2, {`F7_BASE, 5'd31}));
        add_instr(itype_word(`F3_SRL_SRA, 5'd20, 5'd1, {`F7_BASE, 5'd4}));
        add_instr(itype_word(`F3_SRL_SRA, 5'd21, 5'd1, {`F7_ALT, 5'd4}));
        // Writes to x0 and unsupported words
        add_instr(rtype_word(`F3_ADD_SUB, `F7_BASE, 5'd0, 5'd1, 5'd2));
        add_instr(itype_word(`F3_ADD_SUB, 5'd0, 5'd0, 12'd7));
        add_instr(32'h0000_0073);
        add_instr(rtype_word(`F3_ADD_SUB, 7'b0000001, 5'd5, 5'd1, 5'd2));
        add_instr(itype_word(`F3_ADD_SUB, 5'd22, 5'd0, 12'd0));
        add_instr(rtype_word(`F3_ADD_SUB, `F7_BASE, 5'd23, 5'd0, 5'd1));
        add_idle();
        add_instr(itype_word(`F3_ADD_SUB, 5'd24, 5'd23, 12'd1));
        add_idle();
        add_idle();
        add_instr(rtype_word(`F3_ADD_SUB, `F7_ALT, 5'd25, 5'd24, 5'd23));
        // Distance 2 and distance 1 sources together
        add_instr(itype_word(`F3_ADD_SUB, 5'd26, 5'd2, 12'd1));
        add_instr(itype_word(`F3_ADD_SUB, 5'd27, 5'd0, 12'd3));
        add_instr(rtype_word(`F3_ADD_SUB, `F7_BASE, 5'd28, 5'd26, 5'd27));

        repeat (200) add_random_instr();
        cycle_limit = table_q.size() + 30;

        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // Quiet pipeline before any stimulus
        repeat (3) begin
            @(negedge clk);
            check_retire();
        end

        for (int i = 0; i < table_q.size(); i++) begin
            @(negedge clk);
            check_retire();
            instr       = table_q[i].instr;
            instr_valid = table_q[i].drive;
            if (table_q[i].retires) begin
                exp_q.push_back('{due: cycle + 2, rd: table_q[i].rd, data: table_q[i].data});
            end
        end

        repeat (6) begin
            @(negedge clk);
            check_retire();
            instr       = '0;
            instr_valid = 1'b0;
        end

        if (exp_q.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("%0d expected retirements never appeared", exp_q.size());
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

//--- rv_alu_core.f
+incdir+.
cpu_pkg.sv
instr_decoder.sv
register_file.sv
execute_stage.sv
rv_alu_core.sv
rv_alu_core_tb.sv

//--- Makefile
TOP := rv_alu_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f rv_alu_core.f --top-module $(TOP) -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
